/* hw/hdr_pkg.sv */
//==================================================
// widths, opcodes and stream structs of the HDR
// pixel path, referenced by scoped names
//==================================================
package hdr_pkg;

	localparam int RAW_W = 8;	// sensor pixel
	localparam int SUM_W = 10;	// merged pair, headroom for the carry
	localparam int OUT_W = 8;

	// routing opcode, latched per frame
	typedef enum logic [1:0]
	{
		MODE_CAM0 = 2'd0,
		MODE_CAM1 = 2'd1,
		MODE_HDR  = 2'd2
	} pix_mode_e;

	typedef enum logic [1:0]
	{
		SEQ_HOLD  = 2'd0,
		SEQ_COUNT = 2'd1,
		SEQ_RUN   = 2'd2
	} seq_state_e;

	typedef struct packed
	{
		logic valid;
		logic sop;
		logic eop;
		logic [RAW_W-1:0] pix0;
		logic [RAW_W-1:0] pix1;
	} raw_pair_t;

	typedef struct packed
	{
		logic valid;
		logic sop;
		logic eop;
		logic [RAW_W-1:0] pix0;
		logic [RAW_W-1:0] pix1;
		logic [SUM_W-1:0] sum;
	} merged_t;

	typedef struct packed
	{
		logic valid;
		logic sop;
		logic eop;
		logic [OUT_W-1:0] pix;
	} out_pix_t;

endpackage

/* hw/hdr_video_ctrl.sv */
//==================================================
// switch resync with per-frame mode latch, and the
// sensor reset sequencer released after power-up
//==================================================
`timescale 1ns/1ps
module hdr_video_ctrl
#(
	parameter int CAM_RESET_CYCLES = 2500
)
(
	input  logic               sys_clk_b,
	input  logic               reset_n_b,
	input  logic               vsync_i,
	input  logic [3:0]         switches_i,
	output hdr_pkg::pix_mode_e mode_o,
	output logic               cam_resetb_o
);
	localparam int CNT_W = $clog2(CAM_RESET_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CAM_RESET_CYCLES - 1);

	logic [3:0] sw_meta;
	logic [3:0] sw_sync;
	logic [2:0] vs_sh;	// meta, sync, previous
	logic frame_start;
	hdr_pkg::pix_mode_e mode_dec;
	hdr_pkg::pix_mode_e mode_q;
	hdr_pkg::seq_state_e state_q;
	logic [CNT_W-1:0] cnt_q;
	logic cam_resetb_q;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			sw_meta <= '0;
			sw_sync <= '0;
			vs_sh <= '0;
		end
		else
		begin
			sw_meta <= switches_i;
			sw_sync <= sw_meta;
			vs_sh <= {vs_sh[1:0], vsync_i};
		end
	end

	assign frame_start = vs_sh[1] & ~vs_sh[2];

	// upper two switches carry no routing
	always_comb
	begin
		casez (sw_sync)
			4'b??10: mode_dec = hdr_pkg::MODE_CAM1;
			4'b??11: mode_dec = hdr_pkg::MODE_HDR;
			default: mode_dec = hdr_pkg::MODE_CAM0;	// 01 and 00
		endcase
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			mode_q <= hdr_pkg::MODE_CAM0;
		else if (frame_start)
			mode_q <= mode_dec;	// never mid-frame
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			state_q <= hdr_pkg::SEQ_HOLD;
			cnt_q <= '0;
			cam_resetb_q <= 1'b0;
		end
		else
		begin
			case (state_q)
				hdr_pkg::SEQ_HOLD: state_q <= hdr_pkg::SEQ_COUNT;
				hdr_pkg::SEQ_COUNT:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_LAST)
					begin
						state_q <= hdr_pkg::SEQ_RUN;
						cam_resetb_q <= 1'b1;	// sensors out of reset
					end
				end
				hdr_pkg::SEQ_RUN: state_q <= hdr_pkg::SEQ_RUN;
				default: state_q <= hdr_pkg::SEQ_HOLD;
			endcase
		end
	end

	assign mode_o = mode_q;
	assign cam_resetb_o = cam_resetb_q;

endmodule

/* hw/hdr_merge.sv */
//==================================================
// registers the camera pair with its 10-bit sum
//==================================================
`timescale 1ns/1ps
module hdr_merge
(
	input  logic               sys_clk_b,
	input  logic               reset_n_b,
	input  hdr_pkg::raw_pair_t cam_i,
	output hdr_pkg::merged_t   merged_o
);
	logic valid_q;
	logic sop_q;
	logic eop_q;
	logic [hdr_pkg::RAW_W-1:0] pix0_q;
	logic [hdr_pkg::RAW_W-1:0] pix1_q;
	logic [hdr_pkg::SUM_W-1:0] sum_q;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			valid_q <= 1'b0;
			sop_q <= 1'b0;
			eop_q <= 1'b0;
		end
		else
		begin
			valid_q <= cam_i.valid;
			sop_q <= cam_i.sop;
			eop_q <= cam_i.eop;
		end
	end

	always_ff @(posedge sys_clk_b)
	begin
		pix0_q <= cam_i.pix0;
		pix1_q <= cam_i.pix1;
		sum_q <= hdr_pkg::SUM_W'(cam_i.pix0) + hdr_pkg::SUM_W'(cam_i.pix1);
	end

	assign merged_o = '{valid: valid_q, sop: sop_q, eop: eop_q,
		pix0: pix0_q, pix1: pix1_q, sum: sum_q};

endmodule

/* hw/pixel_select.sv */
//==================================================
// per-mode routing of camera 0, camera 1 or the HDR
// sum, reduced to the 8-bit output pixel
//==================================================
`timescale 1ns/1ps
module pixel_select
(
	input  logic               sys_clk_b,
	input  logic               reset_n_b,
	input  hdr_pkg::pix_mode_e mode_i,
	input  hdr_pkg::merged_t   merged_i,
	output hdr_pkg::out_pix_t  pix_o
);
	logic valid_q;
	logic sop_q;
	logic eop_q;
	logic [hdr_pkg::OUT_W-1:0] pix_q;

	// framing is shared by all three sources
	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			valid_q <= 1'b0;
			sop_q <= 1'b0;
			eop_q <= 1'b0;
		end
		else
		begin
			valid_q <= merged_i.valid;
			sop_q <= merged_i.sop;
			eop_q <= merged_i.eop;
		end
	end

	always_ff @(posedge sys_clk_b)
	begin
		case (mode_i)
			hdr_pkg::MODE_CAM0: pix_q <= merged_i.pix0[hdr_pkg::OUT_W-1:0];
			hdr_pkg::MODE_CAM1: pix_q <= merged_i.pix1[hdr_pkg::OUT_W-1:0];
			hdr_pkg::MODE_HDR: pix_q <= merged_i.sum[hdr_pkg::OUT_W:1];	// floor average
			default: pix_q <= merged_i.pix0[hdr_pkg::OUT_W-1:0];
		endcase
	end

	assign pix_o = '{valid: valid_q, sop: sop_q, eop: eop_q, pix: pix_q};

endmodule

/* hw/credit_tx_fifo.sv */
//==================================================
// output FIFO sent under credit flow control, drops
// on full and flags it until reset
//==================================================
`timescale 1ns/1ps
module credit_tx_fifo
#(
	parameter int FIFO_DEPTH = 8,
	parameter int CREDITS = 4
)
(
	input  logic              sys_clk_b,
	input  logic              reset_n_b,
	input  hdr_pkg::out_pix_t pix_i,
	input  logic              credit_i,
	output hdr_pkg::out_pix_t pix_o,
	output logic              overflow_o
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(CREDITS + 1);
	localparam int WORD_W = hdr_pkg::OUT_W + 2;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);
	localparam logic [CRD_W-1:0] CRD_INIT = CRD_W'(CREDITS);

	logic [WORD_W-1:0] mem [FIFO_DEPTH];	// sop, eop, pix
	logic [WORD_W-1:0] rd_word;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [CRD_W-1:0] credit_q;
	logic overflow_q;
	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (count_q == CNT_FULL);
	assign wr_en = pix_i.valid & ~full;
	assign rd_en = (count_q != '0) & (credit_q != '0);	// one credit per pixel

	always_ff @(posedge sys_clk_b)
	begin
		if (wr_en)
			mem[wr_ptr_q] <= {pix_i.sop, pix_i.eop, pix_i.pix};
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			credit_q <= CRD_INIT;
			overflow_q <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			case ({credit_i, rd_en})
				2'b10: credit_q <= credit_q + 1'b1;	// sink freed a slot
				2'b01: credit_q <= credit_q - 1'b1;
				default: credit_q <= credit_q;
			endcase
			if (pix_i.valid && full)
				overflow_q <= 1'b1;	// sticky
		end
	end

	assign rd_word = mem[rd_ptr_q];
	assign pix_o = '{valid: rd_en, sop: rd_en & rd_word[WORD_W-1],
		eop: rd_en & rd_word[WORD_W-2], pix: rd_word[hdr_pkg::OUT_W-1:0]};
	assign overflow_o = overflow_q;

endmodule

/* hw/hdr_video_top.sv */
//==================================================
// dual-camera HDR pixel core, sys_clk_b domain only
//==================================================
`timescale 1ns/1ps
module hdr_video_top
#(
	parameter int CAM_RESET_CYCLES = 2500,
	parameter int FIFO_DEPTH = 8,
	parameter int CREDITS = 4
)
(
	input  logic               sys_clk_b,
	input  logic               reset_n_b,
	input  hdr_pkg::raw_pair_t cam_i,
	input  logic               vsync_i,
	input  logic [3:0]         switches_i,
	input  logic               credit_i,
	output hdr_pkg::out_pix_t  pix_o,
	output logic               cam_resetb_o,
	output logic               overflow_o
);
	hdr_pkg::pix_mode_e mode;
	hdr_pkg::merged_t merged;
	hdr_pkg::out_pix_t sel_pix;

	hdr_video_ctrl
	#(
		.CAM_RESET_CYCLES	( CAM_RESET_CYCLES	)
	)
	hdr_video_ctrl_i
	(
		.sys_clk_b		( sys_clk_b		),
		.reset_n_b		( reset_n_b		),
		.vsync_i		( vsync_i		),
		.switches_i		( switches_i	),
		.mode_o			( mode			),
		.cam_resetb_o	( cam_resetb_o	)
	);

	hdr_merge hdr_merge_i
	(
		.sys_clk_b		( sys_clk_b		),
		.reset_n_b		( reset_n_b		),
		.cam_i			( cam_i			),
		.merged_o		( merged		)
	);

	// stage 2, routing per frame mode
	pixel_select pixel_select_i
	(
		.sys_clk_b		( sys_clk_b		),
		.reset_n_b		( reset_n_b		),
		.mode_i			( mode			),
		.merged_i		( merged		),
		.pix_o			( sel_pix		)
	);

	credit_tx_fifo
	#(
		.FIFO_DEPTH		( FIFO_DEPTH	),
		.CREDITS		( CREDITS		)
	)
	credit_tx_fifo_i
	(
		.sys_clk_b		( sys_clk_b		),
		.reset_n_b		( reset_n_b		),
		.pix_i			( sel_pix		),
		.credit_i		( credit_i		),
		.pix_o			( pix_o			),
		.overflow_o		( overflow_o	)
	);

endmodule

/* include/tb_checks.svh */
//==================================================
// compare tasks and error counters for the testbench
//==================================================
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned err_cnt = 0;
int unsigned check_cnt = 0;

task automatic check_pix(input string name, input hdr_pkg::out_pix_t got,
	input hdr_pkg::out_pix_t exp);
	check_cnt++;
	if (got !== exp)
	begin
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	check_cnt++;
	if (got !== exp)
	begin
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		err_cnt++;
	end
endtask

`endif

/* verification/tb_hdr_video_top.sv */
//==================================================
// directed testbench for the HDR pixel core, acts as
// camera source and as credit sink on pix_o
//==================================================
`timescale 1ns/1ps
module tb_hdr_video_top;
	localparam int CAM_RESET_CYCLES = 20;
	localparam int FIFO_DEPTH = 8;
	localparam int CREDITS = 4;
	localparam int MAX_CYCLES = 2000;

	logic sys_clk_b;
	logic reset_n_b;
	hdr_pkg::raw_pair_t cam_i;
	logic vsync_i;
	logic [3:0] switches_i;
	logic credit_i = 1'b0;
	hdr_pkg::out_pix_t pix_o;
	logic cam_resetb_o;
	logic overflow_o;

	int seed = 19775;
	int cycle_cnt = 0;
	int owed = 0;	// credits held back by the sink
	int rx_base = 0;
	logic hold_credits = 1'b0;
	logic [1:0] credit_pipe = '0;
	hdr_pkg::pix_mode_e cur_mode = hdr_pkg::MODE_CAM0;
	hdr_pkg::out_pix_t rx_q[$];
	hdr_pkg::out_pix_t exp_q[$];

	`include "tb_checks.svh"

	hdr_video_top
	#(
		.CAM_RESET_CYCLES	( CAM_RESET_CYCLES	),
		.FIFO_DEPTH			( FIFO_DEPTH		),
		.CREDITS			( CREDITS			)
	)
	hdr_video_top_i
	(
		.sys_clk_b		( sys_clk_b		),
		.reset_n_b		( reset_n_b		),
		.cam_i			( cam_i			),
		.vsync_i		( vsync_i		),
		.switches_i		( switches_i	),
		.credit_i		( credit_i		),
		.pix_o			( pix_o			),
		.cam_resetb_o	( cam_resetb_o	),
		.overflow_o		( overflow_o	)
	);

	always #50 sys_clk_b = ~sys_clk_b;

	always @(posedge sys_clk_b)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	// sink, each credit goes back two cycles after its pixel
	always @(negedge sys_clk_b)
	begin
		if (pix_o.valid)
		begin
			rx_q.push_back(pix_o);
			if (hold_credits)
				owed++;
		end
		if (credit_pipe[1])
			credit_i = 1'b1;
		else if (!hold_credits && owed > 0)
		begin
			credit_i = 1'b1;
			owed--;
		end
		else
			credit_i = 1'b0;
		credit_pipe = {credit_pipe[0], pix_o.valid & ~hold_credits};
	end

	function automatic hdr_pkg::pix_mode_e decode_mode(input logic [3:0] sw);
		case (sw[1:0])
			2'b10: return hdr_pkg::MODE_CAM1;
			2'b11: return hdr_pkg::MODE_HDR;
			default: return hdr_pkg::MODE_CAM0;
		endcase
	endfunction

	function automatic logic [7:0] expected_pix(input logic [7:0] p0, input logic [7:0] p1);
		int total;
		total = int'(p0) + int'(p1);
		case (cur_mode)
			hdr_pkg::MODE_CAM1: return p1;
			hdr_pkg::MODE_HDR: return 8'(total / 2);	// floor average
			default: return p0;
		endcase
	endfunction

	task automatic send_pairs(input int n);
		hdr_pkg::out_pix_t e;
		for (int i = 0; i < n; i++)
		begin
			cam_i.valid = 1'b1;
			cam_i.sop = (i == 0);
			cam_i.eop = (i == n - 1);
			cam_i.pix0 = 8'($random(seed));
			cam_i.pix1 = 8'($random(seed));
			e.valid = 1'b1;
			e.sop = cam_i.sop;
			e.eop = cam_i.eop;
			e.pix = expected_pix(cam_i.pix0, cam_i.pix1);
			exp_q.push_back(e);
			@(negedge sys_clk_b);
		end
		cam_i = '0;
	endtask

	// drains returned credits, then sets the sink policy
	task automatic start_batch(input logic hold);
		repeat (4) @(posedge sys_clk_b);
		hold_credits = hold;
		rx_base = rx_q.size();
		exp_q.delete();
		@(negedge sys_clk_b);
	endtask

	task automatic wait_pixels(input int n);
		int waited;
		waited = 0;
		do
		begin
			@(posedge sys_clk_b);
			waited++;
		end
		while (rx_q.size() - rx_base < n && waited < 40);
		if (rx_q.size() - rx_base < n)
		begin
			$display("only %0d of %0d pixels arrived on pix_o", rx_q.size() - rx_base, n);
			err_cnt++;
		end
		@(negedge sys_clk_b);
	endtask

	task automatic compare_rx(input int n);
		for (int i = 0; i < n && rx_base + i < rx_q.size(); i++)
			check_pix($sformatf("pix_o[%0d]", i), rx_q[rx_base + i], exp_q[i]);
	endtask

	task automatic expect_count(input int n);
		if (rx_q.size() - rx_base != n)
		begin
			$display("%0d pixels arrived on pix_o where %0d were due", rx_q.size() - rx_base, n);
			err_cnt++;
		end
	endtask

	task automatic set_switches(input logic [3:0] sw);
		switches_i = sw;
		repeat (3) @(negedge sys_clk_b);	// through the sync flops
	endtask

	task automatic pulse_vsync();
		vsync_i = 1'b1;
		@(negedge sys_clk_b);
		vsync_i = 1'b0;
		repeat (5) @(negedge sys_clk_b);
		cur_mode = decode_mode(switches_i);
	endtask

	task automatic test_reset_release();
		int cycles;
		cycles = 0;
		check_bit("pix_o.valid", pix_o.valid, 1'b0);
		check_bit("overflow_o", overflow_o, 1'b0);
		check_bit("cam_resetb_o", cam_resetb_o, 1'b0);
		while (!cam_resetb_o && cycles < 40)
		begin
			@(negedge sys_clk_b);
			cycles++;
		end
		if (cycles < CAM_RESET_CYCLES || cycles > CAM_RESET_CYCLES + 2)
		begin
			$display("cam_resetb_o rose %0d cycles after reset release, out of window", cycles);
			err_cnt++;
		end
	endtask

	task automatic test_default_cam0();
		start_batch(1'b0);
		send_pairs(6);
		wait_pixels(6);
		compare_rx(6);
	endtask

	task automatic test_mode_switch();
		start_batch(1'b0);
		set_switches(4'b0010);
		send_pairs(4);	// no vsync yet, still camera 0
		wait_pixels(4);
		compare_rx(4);
		start_batch(1'b0);
		pulse_vsync();
		send_pairs(4);
		wait_pixels(4);
		compare_rx(4);
	endtask

	task automatic test_hdr();
		start_batch(1'b0);
		set_switches(4'b0011);
		pulse_vsync();
		send_pairs(8);
		wait_pixels(8);
		compare_rx(8);
	endtask

	task automatic test_backpressure();
		start_batch(1'b1);
		send_pairs(6);
		wait_pixels(CREDITS);
		repeat (10) @(posedge sys_clk_b);
		expect_count(CREDITS);
		hold_credits = 1'b0;
		wait_pixels(6);
		compare_rx(6);
		check_bit("overflow_o", overflow_o, 1'b0);
	endtask

	task automatic test_overflow();
		start_batch(1'b1);
		send_pairs(FIFO_DEPTH + CREDITS + 2);
		repeat (4) @(negedge sys_clk_b);
		check_bit("overflow_o", overflow_o, 1'b1);
		@(posedge sys_clk_b);
		hold_credits = 1'b0;
		wait_pixels(FIFO_DEPTH + CREDITS);
		repeat (4) @(posedge sys_clk_b);
		expect_count(FIFO_DEPTH + CREDITS);	// the last two were dropped
		compare_rx(FIFO_DEPTH + CREDITS);
		@(negedge sys_clk_b);
		check_bit("overflow_o", overflow_o, 1'b1);
	endtask

	initial
	begin
		sys_clk_b = 1'b0;
		reset_n_b = 1'b0;
		cam_i = '0;
		vsync_i = 1'b0;
		switches_i = 4'b0000;
		repeat (4) @(negedge sys_clk_b);
		reset_n_b = 1'b1;
		test_reset_release();
		test_default_cam0();
		test_mode_switch();
		test_hdr();
		test_backpressure();
		test_overflow();
		$display("%0d errors in %0d checks", err_cnt, check_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+include
hw/hdr_pkg.sv
hw/hdr_video_ctrl.sv
hw/hdr_merge.sv
hw/pixel_select.sv
hw/credit_tx_fifo.sv
hw/hdr_video_top.sv
verification/tb_hdr_video_top.sv

/* Makefile */
SIM      = verilator
TOP      = tb_hdr_video_top
FILELIST = build.f
FLAGS    = --binary --timing --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
